/* src/icache_pkg.sv */
package icache_pkg;

    ////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////

    // words per line is fixed at four
    localparam int offset_width = 2;

    // widest index the struct can carry
    localparam int index_max_width = 8;

    // tag of the narrowest index (two bits), the real tag is its upper part
    localparam int tag_max_width = 32 - 2 - offset_width - 2;

    typedef logic [31:0]                  addr_t;
    typedef logic [31:0]                  word_t;
    typedef logic [63:0]                  pair_t;
    typedef logic [127:0]                 line_t;
    typedef logic [tag_max_width-1:0]     tag_t;
    typedef logic [index_max_width-1:0]   index_t;
    typedef logic [offset_width-1:0]      offset_t;

    // addi x0, x0, 0
    localparam word_t nop_insn = 32'h0000_0013;

    ////////////////////////////////////////////////////
    // bundles
    ////////////////////////////////////////////////////

    typedef struct packed {
        tag_t    tag;
        index_t  index;
        offset_t offset;
        addr_t   addr;
    } icache_req_t;

    typedef struct packed {
        pair_t pair;
        logic  flag;
        logic  resp_valid;
    } icache_resp_t;

    typedef enum logic [2:0] {
        idle,
        lookup,
        miss_req,
        miss_wait,
        refill
    } ctrl_state_e;

endpackage

/* src/icache_req_buf.sv */
`timescale 1ns/100ps

module icache_req_buf #(
    parameter int index_width = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req_we,
    input  icache_pkg::addr_t       addr,
    output icache_pkg::icache_req_t req
);

    icache_pkg::addr_t addr_q;

    // accepted fetch address
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_q <= '0;
        end else if (req_we) begin
            addr_q <= addr;
        end
    end

    // field split, tag is left aligned in the widest tag vector
    always_comb begin
        req.tag    = addr_q[31:32-icache_pkg::tag_max_width];
        req.index  = icache_pkg::index_t'(addr_q[index_width+3:4]);
        req.offset = addr_q[icache_pkg::offset_width+1:2];
        req.addr   = addr_q;
    end

endmodule

/* src/icache_tag_array.sv */
`timescale 1ns/100ps

module icache_tag_array #(
    parameter int index_width = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [index_width-1:0]  rd_index,
    input  icache_pkg::icache_req_t req,
    input  logic [1:0]              tag_we,
    output logic [1:0]              hit
);

    localparam int sets      = 1 << index_width;
    localparam int tag_width = 32 - 2 - icache_pkg::offset_width - index_width;

    logic [tag_width-1:0] tag_mem [2][sets];
    logic [tag_width-1:0] rd_tag_q [2];
    logic [sets-1:0]      valid_q [2];
    logic [1:0]           rd_valid_q;
    logic [tag_width-1:0] req_tag;
    logic [index_width-1:0] wr_index;

    // only the upper part of the wide tag is meaningful here
    assign req_tag  = req.tag[icache_pkg::tag_max_width-1 -: tag_width];
    assign wr_index = req.index[index_width-1:0];

    // tag storage with registered read
    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (tag_we[w]) begin
                tag_mem[w][wr_index] <= req_tag;
            end
            rd_tag_q[w] <= tag_mem[w][rd_index];
        end
    end

    // valid bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < 2; w++) begin
                valid_q[w] <= '0;
            end
            rd_valid_q <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (tag_we[w]) begin
                    valid_q[w][wr_index] <= 1'b1;
                end
                rd_valid_q[w] <= valid_q[w][rd_index];
            end
        end
    end

    for (genvar w = 0; w < 2; w++) begin : g_cmp
        assign hit[w] = rd_valid_q[w] && (rd_tag_q[w] == req_tag);
    end

endmodule

/* src/icache_data_array.sv */
`timescale 1ns/100ps

module icache_data_array #(
    parameter int index_width = 4
) (
    input  logic                   clk,
    input  logic [index_width-1:0] rd_index,
    input  logic [index_width-1:0] wr_index,
    input  logic [1:0]             data_we,
    input  icache_pkg::line_t      wr_line,
    output icache_pkg::line_t      line0,
    output icache_pkg::line_t      line1
);

    localparam int sets = 1 << index_width;

    icache_pkg::line_t line_mem [2][sets];
    icache_pkg::line_t rd_line_q [2];

    // whole line written on refill, read one cycle later
    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (data_we[w]) begin
                line_mem[w][wr_index] <= wr_line;
            end
            rd_line_q[w] <= line_mem[w][rd_index];
        end
    end

    assign line0 = rd_line_q[0];
    assign line1 = rd_line_q[1];

endmodule

/* src/icache_lru.sv */
`timescale 1ns/100ps

module icache_lru #(
    parameter int index_width = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [index_width-1:0] index,
    input  logic                   touch,
    input  logic                   touched_way,
    output logic                   victim
);

    localparam int sets = 1 << index_width;

    // per set, the way used least recently
    logic [sets-1:0] lru_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lru_q <= '0;
        end else if (touch) begin
            lru_q[index] <= ~touched_way;
        end
    end

    assign victim = lru_q[index];

endmodule

/* src/icache_fetch_sel.sv */
`timescale 1ns/100ps

module icache_fetch_sel (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     stall,
    input  logic                     sel_way,
    input  logic                     sel_return,
    input  icache_pkg::line_t        line0,
    input  icache_pkg::line_t        line1,
    input  icache_pkg::line_t        mem_data,
    input  icache_pkg::offset_t      offset,
    input  logic                     resp_valid_in,
    output icache_pkg::icache_resp_t resp
);

    icache_pkg::line_t line_sel;
    icache_pkg::word_t word_lo;
    icache_pkg::word_t word_hi;
    icache_pkg::pair_t pair_cur;
    logic              flag_cur;
    icache_pkg::pair_t pair_q;
    logic              flag_q;

    // refill data bypasses the arrays
    always_comb begin
        if (sel_return) begin
            line_sel = mem_data;
        end else begin
            line_sel = sel_way ? line1 : line0;
        end
    end

    // word at the fetch address, then its neighbour if it is in the same half
    always_comb begin
        word_lo  = line_sel[32*offset +: 32];
        word_hi  = line_sel[32*{offset[1], 1'b1} +: 32];
        flag_cur = ~offset[0];
        pair_cur = flag_cur ? {word_hi, word_lo} : {icache_pkg::nop_insn, word_lo};
    end

    // last delivered pair
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pair_q <= {icache_pkg::nop_insn, icache_pkg::nop_insn};
            flag_q <= 1'b0;
        end else if (resp_valid_in && !stall) begin
            pair_q <= pair_cur;
            flag_q <= flag_cur;
        end
    end

    always_comb begin
        resp.pair       = (resp_valid_in && !stall) ? pair_cur : pair_q;
        resp.flag       = (resp_valid_in && !stall) ? flag_cur : flag_q;
        resp.resp_valid = resp_valid_in && !stall;
    end

endmodule

/* src/icache_ctrl.sv */
`timescale 1ns/100ps

module icache_ctrl #(
    parameter int index_width = 4
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       valid,
    input  logic       stall,
    input  logic [1:0] hit,
    input  logic       victim,
    input  logic       mem_addr_ok,
    input  logic       mem_data_ok,
    output logic       ready,
    output logic       req_we,
    output logic       mem_req,
    output logic [1:0] tag_we,
    output logic [1:0] data_we,
    output logic       lru_touch,
    output logic       lru_way,
    output logic       sel_way,
    output logic       sel_return,
    output logic       resp_valid
);

    // the wide tag vector assumes at least two index bits
    if (index_width < 2 || index_width > icache_pkg::index_max_width) begin : g_bad_index
        $error("icache index_width out of range");
    end

    icache_pkg::ctrl_state_e state_q;
    icache_pkg::ctrl_state_e state_d;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= icache_pkg::idle;
        end else begin
            state_q <= state_d;
        end
    end

    ////////////////////////////////////////////////////
    // next state and strobes
    ////////////////////////////////////////////////////

    assign sel_way = hit[1];
    assign mem_req = (state_q == icache_pkg::miss_req);

    always_comb begin
        state_d    = state_q;
        ready      = 1'b0;
        req_we     = 1'b0;
        tag_we     = 2'b00;
        data_we    = 2'b00;
        lru_touch  = 1'b0;
        lru_way    = hit[1];
        sel_return = 1'b0;
        resp_valid = 1'b0;
        case (state_q)
            icache_pkg::idle: begin
                ready  = !stall;
                req_we = valid && !stall;
                if (req_we) begin
                    state_d = icache_pkg::lookup;
                end
            end
            icache_pkg::lookup: begin
                if (hit == 2'b00) begin
                    state_d = icache_pkg::miss_req;
                end else if (!stall) begin
                    // answer and take the next request in the same cycle
                    resp_valid = 1'b1;
                    lru_touch  = 1'b1;
                    ready      = 1'b1;
                    req_we     = valid;
                    state_d    = valid ? icache_pkg::lookup : icache_pkg::idle;
                end
            end
            icache_pkg::miss_req: begin
                if (mem_addr_ok) begin
                    state_d = icache_pkg::miss_wait;
                end
            end
            icache_pkg::miss_wait: begin
                if (mem_data_ok) begin
                    tag_we     = {victim, ~victim};
                    data_we    = {victim, ~victim};
                    lru_touch  = 1'b1;
                    lru_way    = victim;
                    sel_return = 1'b1;
                    resp_valid = !stall;
                    // stalled refill answers later from the arrays
                    state_d    = stall ? icache_pkg::refill : icache_pkg::idle;
                end
            end
            icache_pkg::refill: begin
                // arrays re-read the new line before lookup
                state_d = icache_pkg::lookup;
            end
            default: begin
                state_d = icache_pkg::idle;
            end
        endcase
    end

endmodule

/* src/icache_top.sv */
`timescale 1ns/100ps

module icache_top #(
    parameter int index_width = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     valid,
    input  icache_pkg::addr_t        addr,
    input  logic                     stall,
    input  logic                     mem_addr_ok,
    input  logic                     mem_data_ok,
    input  icache_pkg::line_t        mem_data,
    output logic                     ready,
    output icache_pkg::icache_resp_t resp,
    output logic                     mem_req,
    output icache_pkg::addr_t        mem_addr
);

    icache_pkg::icache_req_t req;
    logic                    req_we;
    logic [index_width-1:0]  rd_index;
    logic [index_width-1:0]  buf_index;
    logic [1:0]              hit;
    logic [1:0]              tag_we;
    logic [1:0]              data_we;
    icache_pkg::line_t       line0;
    icache_pkg::line_t       line1;
    logic                    victim;
    logic                    lru_touch;
    logic                    lru_way;
    logic                    sel_way;
    logic                    sel_return;
    logic                    resp_valid;

    assign buf_index = req.index[index_width-1:0];

    // fresh index on acceptance, otherwise keep reading the buffered set
    assign rd_index = req_we ? addr[index_width+3:4] : buf_index;

    // line aligned refill address
    assign mem_addr = {req.addr[31:icache_pkg::offset_width+2],
                       {(icache_pkg::offset_width+2){1'b0}}};

    ////////////////////////////////////////////////////
    // datapath
    ////////////////////////////////////////////////////

    icache_req_buf #(.index_width(index_width)) u_req_buf (
        .clk(clk), .rst_n(rst_n), .req_we(req_we), .addr(addr), .req(req)
    );

    icache_tag_array #(.index_width(index_width)) u_tag_array (
        .clk(clk), .rst_n(rst_n), .rd_index(rd_index), .req(req),
        .tag_we(tag_we), .hit(hit)
    );

    icache_data_array #(.index_width(index_width)) u_data_array (
        .clk(clk), .rd_index(rd_index), .wr_index(buf_index), .data_we(data_we),
        .wr_line(mem_data), .line0(line0), .line1(line1)
    );

    icache_lru #(.index_width(index_width)) u_lru (
        .clk(clk), .rst_n(rst_n), .index(buf_index), .touch(lru_touch),
        .touched_way(lru_way), .victim(victim)
    );

    icache_fetch_sel u_fetch_sel (
        .clk(clk), .rst_n(rst_n), .stall(stall), .sel_way(sel_way),
        .sel_return(sel_return), .line0(line0), .line1(line1), .mem_data(mem_data),
        .offset(req.offset), .resp_valid_in(resp_valid), .resp(resp)
    );

    ////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////

    icache_ctrl #(.index_width(index_width)) u_ctrl (
        .clk(clk), .rst_n(rst_n), .valid(valid), .stall(stall), .hit(hit),
        .victim(victim), .mem_addr_ok(mem_addr_ok), .mem_data_ok(mem_data_ok),
        .ready(ready), .req_we(req_we), .mem_req(mem_req), .tag_we(tag_we),
        .data_we(data_we), .lru_touch(lru_touch), .lru_way(lru_way),
        .sel_way(sel_way), .sel_return(sel_return), .resp_valid(resp_valid)
    );

endmodule

/* tests/icache_assert.sv */
`timescale 1ns/100ps

module icache_assert #(
    parameter int index_width = 4
) (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     valid,
    input logic                     ready,
    input logic                     stall,
    input icache_pkg::addr_t        addr,
    input icache_pkg::icache_resp_t resp,
    input logic                     mem_req,
    input icache_pkg::addr_t        mem_addr,
    input logic                     mem_addr_ok,
    input logic                     mem_data_ok
);

    localparam int sets      = 1 << index_width;
    localparam int tag_width = 28 - index_width;

    // shadow copy of tags, valid bits and recency
    logic [tag_width-1:0]   mtag [2][sets];
    logic [sets-1:0]        mvalid [2];
    logic [sets-1:0]        mlru;
    icache_pkg::addr_t      acc_q;
    logic [index_width-1:0] fetch_set;
    logic [tag_width-1:0]   fetch_tag;
    logic [index_width-1:0] acc_set;
    logic [tag_width-1:0]   acc_tag;
    logic [1:0]             pred_way;
    logic [1:0]             acc_way;
    int unsigned            fails;

    function automatic icache_pkg::word_t mem_word(input icache_pkg::addr_t a);
        return {a[31:2], 2'b00} ^ 32'hA5A5_0000;
    endfunction

    assign fetch_set = addr[index_width+3:4];
    assign fetch_tag = addr[31:index_width+4];
    assign acc_set   = acc_q[index_width+3:4];
    assign acc_tag   = acc_q[31:index_width+4];

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            pred_way[w] = mvalid[w][fetch_set] && (mtag[w][fetch_set] == fetch_tag);
            acc_way[w]  = mvalid[w][acc_set] && (mtag[w][acc_set] == acc_tag);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < 2; w++) begin
                mvalid[w] <= '0;
            end
            mlru  <= '0;
            acc_q <= '0;
        end else begin
            if (valid && ready) begin
                acc_q <= addr;
            end
            // refill goes to the least recent way
            if (mem_data_ok) begin
                mtag[mlru[acc_set]][acc_set]   <= acc_tag;
                mvalid[mlru[acc_set]][acc_set] <= 1'b1;
                mlru[acc_set]                  <= ~mlru[acc_set];
            end else if (resp.resp_valid && acc_way != 2'b00) begin
                mlru[acc_set] <= ~acc_way[1];
            end
        end
    end

    //////////////////////////////////////////////////
    // response data and flag
    //////////////////////////////////////////////////

    a_low_word: assert property (@(posedge clk) disable iff (!rst_n)
        resp.resp_valid |-> resp.pair[31:0] == mem_word(acc_q))
        else begin
            fails++;
            $error("mismatch resp.pair[31:0] %h expected %h",
                   $sampled(resp.pair[31:0]), mem_word($sampled(acc_q)));
        end

    a_high_word: assert property (@(posedge clk) disable iff (!rst_n)
        resp.resp_valid && !acc_q[2] |-> resp.pair[63:32] == mem_word(acc_q + 32'd4))
        else begin
            fails++;
            $error("mismatch resp.pair[63:32] %h expected %h",
                   $sampled(resp.pair[63:32]), mem_word($sampled(acc_q) + 32'd4));
        end

    a_flag_even: assert property (@(posedge clk) disable iff (!rst_n)
        resp.resp_valid && !acc_q[2] |-> resp.flag)
        else begin
            fails++;
            $error("mismatch resp.flag %h expected 1", $sampled(resp.flag));
        end

    a_odd_nop: assert property (@(posedge clk) disable iff (!rst_n)
        resp.resp_valid && acc_q[2] |-> !resp.flag && resp.pair[63:32] == 32'h0000_0013)
        else begin
            fails++;
            $error("mismatch resp.flag %h resp.pair[63:32] %h expected 0 and 00000013",
                   $sampled(resp.flag), $sampled(resp.pair[63:32]));
        end

    //////////////////////////////////////////////////
    // hit and miss timing
    //////////////////////////////////////////////////

    // a miss would raise mem_req two cycles after acceptance
    a_hit_latency: assert property (@(posedge clk) disable iff (!rst_n)
        valid && ready && pred_way != 2'b00 |=> (resp.resp_valid || stall) ##1 !mem_req)
        else begin
            fails++;
            $error("a fetch of a cached line got no response in time or raised mem_req");
        end

    a_miss_req: assert property (@(posedge clk) disable iff (!rst_n)
        valid && ready && pred_way == 2'b00 |-> ##2 mem_req)
        else begin
            fails++;
            $error("a fetch of an uncached line raised no memory request");
        end

    a_stall_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        stall |-> !resp.resp_valid && !ready)
        else begin
            fails++;
            $error("the cache responded or accepted a fetch under stall");
        end

    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        stall |-> resp.pair == $past(resp.pair) && resp.flag == $past(resp.flag))
        else begin
            fails++;
            $error("mismatch resp.pair %h expected %h under stall",
                   $sampled(resp.pair), $past(resp.pair));
        end

    //////////////////////////////////////////////////
    // memory handshake and reset
    //////////////////////////////////////////////////

    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req && !mem_addr_ok |=> mem_req)
        else begin
            fails++;
            $error("mem_req dropped before mem_addr_ok");
        end

    a_req_drop: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req && mem_addr_ok |=> !mem_req)
        else begin
            fails++;
            $error("mem_req stayed high after mem_addr_ok");
        end

    // line of the missed fetch, low four bits clear
    a_addr_align: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req |-> mem_addr == {acc_q[31:4], 4'h0})
        else begin
            fails++;
            $error("mismatch mem_addr %h expected %h",
                   $sampled(mem_addr), {$sampled(acc_q[31:4]), 4'h0});
        end

    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !mem_req && !resp.resp_valid)
        else begin
            fails++;
            $error("mem_req or resp_valid high during reset");
        end

endmodule

bind icache_top icache_assert #(.index_width(index_width)) u_icache_assert (
    .clk(clk), .rst_n(rst_n), .valid(valid), .ready(ready), .stall(stall),
    .addr(addr), .resp(resp), .mem_req(mem_req), .mem_addr(mem_addr),
    .mem_addr_ok(mem_addr_ok), .mem_data_ok(mem_data_ok)
);

/* tests/tb_icache.sv */
`timescale 1ns/100ps

module tb_icache;

    logic                     clk;
    logic                     rst_n;
    logic                     valid;
    icache_pkg::addr_t        addr;
    logic                     stall;
    logic                     mem_addr_ok;
    logic                     mem_data_ok;
    icache_pkg::line_t        mem_data;
    logic                     ready;
    icache_pkg::icache_resp_t resp;
    logic                     mem_req;
    icache_pkg::addr_t        mem_addr;
    logic [15:0]              stim_lfsr;
    logic [15:0]              mem_lfsr;

    icache_top #(.index_width(4)) u_icache_top (
        .clk(clk), .rst_n(rst_n), .valid(valid), .addr(addr), .stall(stall),
        .mem_addr_ok(mem_addr_ok), .mem_data_ok(mem_data_ok), .mem_data(mem_data),
        .ready(ready), .resp(resp), .mem_req(mem_req), .mem_addr(mem_addr)
    );

    always #5 clk = ~clk;

    // 16 bit fibonacci, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(inout logic [15:0] st, input int n, output int unsigned v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            st = lfsr_step(st);
            v  = {v[30:0], st[0]};
        end
    endtask

    function automatic icache_pkg::addr_t pool_addr(input int unsigned t, input int unsigned s,
                                                    input int unsigned w);
        return 32'h0001_0000 + (t << 12) + (s << 4) + (w << 2);
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    // any failed bound check ends the run
    always @(negedge clk) begin
        if (u_icache_top.u_icache_assert.fails != 0) begin
            stop_with_failure("a bound assertion failed");
        end
    end

    //////////////////////////////////////////////////
    // memory model
    //////////////////////////////////////////////////

    task automatic serve_line();
        icache_pkg::addr_t base;
        icache_pkg::line_t line;
        int unsigned       d;
        base = mem_addr;
        for (int i = 0; i < 4; i++) begin
            line[32*i +: 32] = (base + 32'(4 * i)) ^ 32'hA5A5_0000;
        end
        take_bits(mem_lfsr, 2, d);
        repeat ((d % 3) + 1) @(posedge clk);
        #1;
        mem_addr_ok = 1'b1;
        @(posedge clk);
        #1;
        mem_addr_ok = 1'b0;
        take_bits(mem_lfsr, 2, d);
        repeat (d + 1) @(posedge clk);
        #1;
        mem_data_ok = 1'b1;
        mem_data    = line;
        @(posedge clk);
        #1;
        mem_data_ok = 1'b0;
        mem_data    = '0;
    endtask

    always begin
        @(posedge clk);
        #1;
        if (rst_n && mem_req) begin
            serve_line();
        end
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    // hold the address until it is taken
    task automatic fetch(input icache_pkg::addr_t a);
        int unsigned n;
        logic        taken;
        valid = 1'b1;
        addr  = a;
        n     = 0;
        taken = 1'b0;
        while (!taken) begin
            if (n == 200) begin
                stop_with_failure("timeout waiting for the cache to accept a fetch");
            end else begin
                @(negedge clk);
                taken = ready;
                @(posedge clk);
                #1;
                n++;
            end
        end
    endtask

    task automatic pause(input int unsigned cycles, input logic hold);
        valid = 1'b0;
        stall = hold;
        repeat (cycles) begin
            @(posedge clk);
            #1;
        end
        stall = 1'b0;
    endtask

    initial begin
        int unsigned t;
        int unsigned s;
        int unsigned w;
        int unsigned r;
        int unsigned n;
        clk         = 1'b0;
        rst_n       = 1'b0;
        valid       = 1'b0;
        addr        = '0;
        stall       = 1'b0;
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_data    = '0;
        stim_lfsr   = 16'd89;
        mem_lfsr    = 16'd89;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        pause(2, 1'b0);

        // A and B fill set 5, A is touched, C evicts B
        fetch(pool_addr(0, 5, 0));
        fetch(pool_addr(1, 5, 1));
        fetch(pool_addr(0, 5, 2));
        fetch(pool_addr(2, 5, 3));
        fetch(pool_addr(0, 5, 0));
        fetch(pool_addr(1, 5, 2));
        pause(2, 1'b0);

        // repeated address, then each word of that line
        for (int i = 0; i < 4; i++) begin
            fetch(pool_addr(3, 2, 1));
        end
        for (int i = 0; i < 4; i++) begin
            fetch(pool_addr(3, 2, i));
        end
        pause(3, 1'b1);

        // long stall across a refill
        fetch(pool_addr(2, 9, 0));
        pause(10, 1'b1);
        fetch(pool_addr(2, 9, 2));
        pause(2, 1'b1);

        for (int k = 0; k < 150; k++) begin
            take_bits(stim_lfsr, 2, t);
            take_bits(stim_lfsr, 2, s);
            take_bits(stim_lfsr, 2, w);
            fetch(pool_addr(t, s, w));
            take_bits(stim_lfsr, 3, r);
            if (r == 0) begin
                take_bits(stim_lfsr, 3, n);
                pause(n + 1, 1'b1);
            end else if (r == 1) begin
                pause(1, 1'b0);
            end
        end

        // drain the last request
        valid = 1'b0;
        n     = 0;
        @(negedge clk);
        while (!(ready && !mem_req)) begin
            if (n == 60) begin
                stop_with_failure("timeout waiting for the cache to go idle");
            end else begin
                @(negedge clk);
                n++;
            end
        end
        repeat (4) @(posedge clk);
        #1;
        if (u_icache_top.u_icache_assert.fails == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            stop_with_failure("bound assertion failures were recorded");
        end
    end

endmodule

/* project.f */
src/icache_pkg.sv
src/icache_req_buf.sv
src/icache_tag_array.sv
src/icache_data_array.sv
src/icache_lru.sv
src/icache_fetch_sel.sv
src/icache_ctrl.sv
src/icache_top.sv
tests/icache_assert.sv
tests/tb_icache.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --assert --top-module tb_icache -f project.f -o sim_icache
	./obj_dir/sim_icache +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
